// ==== hdl/axil_link_macros.svh ====
// ================================================
// AXI4-Lite link widths and depths
// Shared by the package and all link RTL
// ================================================

`ifndef AXIL_LINK_MACROS_SVH
`define AXIL_LINK_MACROS_SVH

// AXI4-Lite bus widths
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32

// Link command payload, one word per command
`define LINK_DATA_W 8
`define LINK_ADDR_W (`AXIL_DATA_W - `LINK_DATA_W - 1)

// Entries in each link FIFO
`define LINK_FIFO_DEPTH 4

// Endpoint decodes this many address bits
`define MEM_ADDR_W 8

`endif

// ==== hdl/axil_link_pkg.sv ====
// ================================================
// AXI4-Lite link package
// Response codes and link word formats
// ================================================

`include "axil_link_macros.svh"

package axil_link_pkg;

  // AXI response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  // Command word sent from the packer to the remote store
  // Data is zero for reads
  typedef struct packed {
    logic                      write_not_read;
    logic [`LINK_ADDR_W-1:0]   addr;
    logic [`LINK_DATA_W-1:0]   data;
  } link_cmd_s;

  // Response word returned for reads
  typedef struct packed {
    logic [`AXIL_DATA_W-`LINK_DATA_W-1:0] pad;
    logic [`LINK_DATA_W-1:0]              data;
  } link_rsp_s;

endpackage

// ==== hdl/link_fifo.sv ====
// ================================================
// Link FIFO
// Small synchronous valid/ready queue for any
// payload type
// ================================================

`timescale 1ns/10ps

module link_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  depth_p   = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,

  // Push side
  input  payload_t data_i,
  input  logic     v_i,
  output logic     ready_o,

  // Pop side
  output payload_t data_o,
  output logic     v_o,
  input  logic     ready_i
);

  localparam int ptr_w_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int count_w_lp = $clog2(depth_p + 1);

  payload_t                mem [depth_p];
  logic [ptr_w_lp-1:0]     wr_ptr_r;
  logic [ptr_w_lp-1:0]     rd_ptr_r;
  logic [count_w_lp-1:0]   count_r;
  logic                    push;
  logic                    pop;

  assign ready_o = (count_r != count_w_lp'(depth_p));
  assign v_o     = (count_r != '0);
  assign data_o  = mem[rd_ptr_r];

  assign push = v_i && ready_o;
  assign pop  = v_o && ready_i;

  // Entry storage
  always_ff @(posedge clk_i)
  begin
    if (push)
      mem[wr_ptr_r] <= data_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      // Wrap explicitly so any depth works
      if (push)
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      if (push && !pop)
        count_r <= count_r + 1'b1;
      else if (pop && !push)
        count_r <= count_r - 1'b1;
    end
  end

endmodule

// ==== hdl/axil_store_packer.sv ====
// ================================================
// AXI4-Lite store packer
// Packs one AXI4-Lite load or store into a link
// command and waits for it to complete
// ================================================

`timescale 1ns/10ps

`include "axil_link_macros.svh"

module axil_store_packer
  import axil_link_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  // Write address
  input  logic [`AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic [2:0]                s_axil_awprot_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,

  // Write data
  input  logic [`AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,

  // Write response
  output axil_resp_e                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,

  // Read address
  input  logic [`AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic [2:0]                s_axil_arprot_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,

  // Read data
  output logic [`AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output axil_resp_e                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i,

  // Link command out
  output link_cmd_s                 cmd_o,
  output logic                      cmd_v_o,
  input  logic                      cmd_ready_i,

  // Link response in
  input  link_rsp_s                 rsp_i,
  input  logic                      rsp_v_i,
  output logic                      rsp_ready_o
);

  typedef enum logic [2:0] {
    e_ready,
    e_write_req,
    e_read_req,
    e_read_resp,
    e_write_resp
  } state_e;

  state_e    state_r;
  state_e    state_n;
  link_cmd_s write_cmd;
  link_cmd_s read_cmd;

  // No error responses are generated
  assign s_axil_bresp_o = OKAY;
  assign s_axil_rresp_o = OKAY;

  // Read data comes straight from the link response
  assign s_axil_rdata_o = rsp_i;
  assign rsp_ready_o    = s_axil_rready_i;

  // Low address bits and low data byte form the command
  assign write_cmd = '{write_not_read: 1'b1,
                       addr:           s_axil_awaddr_i[`LINK_ADDR_W-1:0],
                       data:           s_axil_wdata_i[`LINK_DATA_W-1:0]};
  assign read_cmd  = '{write_not_read: 1'b0,
                       addr:           s_axil_araddr_i[`LINK_ADDR_W-1:0],
                       data:           '0};

  always_comb
  begin
    s_axil_awready_o = 1'b0;
    s_axil_wready_o  = 1'b0;
    s_axil_arready_o = 1'b0;
    s_axil_bvalid_o  = 1'b0;
    s_axil_rvalid_o  = 1'b0;
    cmd_o            = '0;
    cmd_v_o          = 1'b0;
    state_n          = state_r;

    case (state_r)
      e_ready:
      begin
        // Writes win over reads
        if (s_axil_awvalid_i && s_axil_wvalid_i)
          state_n = e_write_req;
        else if (s_axil_arvalid_i)
          state_n = e_read_req;
      end

      e_write_req:
      begin
        cmd_v_o          = 1'b1;
        cmd_o            = write_cmd;
        s_axil_awready_o = cmd_ready_i;
        s_axil_wready_o  = cmd_ready_i;
        if (cmd_ready_i)
          state_n = e_write_resp;
      end

      e_read_req:
      begin
        cmd_v_o          = 1'b1;
        cmd_o            = read_cmd;
        s_axil_arready_o = cmd_ready_i;
        if (cmd_ready_i)
          state_n = e_read_resp;
      end

      e_read_resp:
      begin
        // Blocks until the remote byte returns
        s_axil_rvalid_o = rsp_v_i;
        if (rsp_v_i && s_axil_rready_i)
          state_n = e_ready;
      end

      e_write_resp:
      begin
        s_axil_bvalid_o = 1'b1;
        if (s_axil_bready_i)
          state_n = e_ready;
      end

      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_ready;
    else
      state_r <= state_n;
  end

endmodule

// ==== hdl/store_endpoint.sv ====
// ================================================
// Remote store endpoint
// Decodes link commands into byte memory writes
// and reads, with a registered read response
// ================================================

`timescale 1ns/10ps

`include "axil_link_macros.svh"

module store_endpoint
  import axil_link_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  // Command in
  input  link_cmd_s cmd_i,
  input  logic      cmd_v_i,
  output logic      cmd_ready_o,

  // Response out
  output link_rsp_s rsp_o,
  output logic      rsp_v_o,
  input  logic      rsp_ready_i
);

  localparam int mem_size_lp = 1 << `MEM_ADDR_W;

  logic [`LINK_DATA_W-1:0] mem [mem_size_lp];
  logic                    clearing_r;
  logic [`MEM_ADDR_W-1:0]  clear_addr_r;
  logic [`MEM_ADDR_W-1:0]  cmd_addr;
  logic [`LINK_DATA_W-1:0] rsp_data_r;
  logic                    rsp_v_r;
  logic                    cmd_fire;
  logic                    wr_fire;
  logic                    rd_fire;

  // Higher address bits alias
  assign cmd_addr = cmd_i.addr[`MEM_ADDR_W-1:0];

  // Reads need the response slot free or draining
  assign cmd_ready_o = !clearing_r &&
                       (cmd_i.write_not_read || !rsp_v_r || rsp_ready_i);

  assign cmd_fire = cmd_v_i && cmd_ready_o;
  assign wr_fire  = cmd_fire && cmd_i.write_not_read;
  assign rd_fire  = cmd_fire && !cmd_i.write_not_read;

  assign rsp_v_o = rsp_v_r;
  assign rsp_o   = '{pad: '0, data: rsp_data_r};

  // Memory clear sweep of one byte per cycle after reset
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      clearing_r   <= 1'b1;
      clear_addr_r <= '0;
    end
    else if (clearing_r)
    begin
      clear_addr_r <= clear_addr_r + 1'b1;
      if (clear_addr_r == '1)
        clearing_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (clearing_r)
      mem[clear_addr_r] <= '0;
    else if (wr_fire)
      mem[cmd_addr] <= cmd_i.data;
  end

  always_ff @(posedge clk_i)
  begin
    if (rd_fire)
      rsp_data_r <= mem[cmd_addr];
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rsp_v_r <= 1'b0;
    else if (rd_fire)
      rsp_v_r <= 1'b1;
    else if (rsp_ready_i)
      rsp_v_r <= 1'b0;
  end

endmodule

// ==== hdl/axil_link_top.sv ====
// ================================================
// AXI4-Lite link top level
// Packer, command and response FIFOs and the
// remote byte store
// ================================================

`timescale 1ns/10ps

`include "axil_link_macros.svh"

module axil_link_top
  import axil_link_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      reset_i,

  input  logic [`AXIL_ADDR_W-1:0]   s_axil_awaddr_i,
  input  logic [2:0]                s_axil_awprot_i,
  input  logic                      s_axil_awvalid_i,
  output logic                      s_axil_awready_o,

  input  logic [`AXIL_DATA_W-1:0]   s_axil_wdata_i,
  input  logic [`AXIL_DATA_W/8-1:0] s_axil_wstrb_i,
  input  logic                      s_axil_wvalid_i,
  output logic                      s_axil_wready_o,

  output axil_resp_e                s_axil_bresp_o,
  output logic                      s_axil_bvalid_o,
  input  logic                      s_axil_bready_i,

  input  logic [`AXIL_ADDR_W-1:0]   s_axil_araddr_i,
  input  logic [2:0]                s_axil_arprot_i,
  input  logic                      s_axil_arvalid_i,
  output logic                      s_axil_arready_o,

  output logic [`AXIL_DATA_W-1:0]   s_axil_rdata_o,
  output axil_resp_e                s_axil_rresp_o,
  output logic                      s_axil_rvalid_o,
  input  logic                      s_axil_rready_i
);

  // Packer side of the link
  link_cmd_s pk_cmd;
  logic      pk_cmd_v;
  logic      pk_cmd_ready;
  link_rsp_s pk_rsp;
  logic      pk_rsp_v;
  logic      pk_rsp_ready;

  // Endpoint side of the link
  link_cmd_s ep_cmd;
  logic      ep_cmd_v;
  logic      ep_cmd_ready;
  link_rsp_s ep_rsp;
  logic      ep_rsp_v;
  logic      ep_rsp_ready;

  axil_store_packer u_packer (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (s_axil_awaddr_i),
    .s_axil_awprot_i  (s_axil_awprot_i),
    .s_axil_awvalid_i (s_axil_awvalid_i),
    .s_axil_awready_o (s_axil_awready_o),
    .s_axil_wdata_i   (s_axil_wdata_i),
    .s_axil_wstrb_i   (s_axil_wstrb_i),
    .s_axil_wvalid_i  (s_axil_wvalid_i),
    .s_axil_wready_o  (s_axil_wready_o),
    .s_axil_bresp_o   (s_axil_bresp_o),
    .s_axil_bvalid_o  (s_axil_bvalid_o),
    .s_axil_bready_i  (s_axil_bready_i),
    .s_axil_araddr_i  (s_axil_araddr_i),
    .s_axil_arprot_i  (s_axil_arprot_i),
    .s_axil_arvalid_i (s_axil_arvalid_i),
    .s_axil_arready_o (s_axil_arready_o),
    .s_axil_rdata_o   (s_axil_rdata_o),
    .s_axil_rresp_o   (s_axil_rresp_o),
    .s_axil_rvalid_o  (s_axil_rvalid_o),
    .s_axil_rready_i  (s_axil_rready_i),
    .cmd_o            (pk_cmd),
    .cmd_v_o          (pk_cmd_v),
    .cmd_ready_i      (pk_cmd_ready),
    .rsp_i            (pk_rsp),
    .rsp_v_i          (pk_rsp_v),
    .rsp_ready_o      (pk_rsp_ready)
  );

  link_fifo #(
    .payload_t (link_cmd_s),
    .depth_p   (`LINK_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (pk_cmd),
    .v_i     (pk_cmd_v),
    .ready_o (pk_cmd_ready),
    .data_o  (ep_cmd),
    .v_o     (ep_cmd_v),
    .ready_i (ep_cmd_ready)
  );

  store_endpoint u_endpoint (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cmd_i       (ep_cmd),
    .cmd_v_i     (ep_cmd_v),
    .cmd_ready_o (ep_cmd_ready),
    .rsp_o       (ep_rsp),
    .rsp_v_o     (ep_rsp_v),
    .rsp_ready_i (ep_rsp_ready)
  );

  link_fifo #(
    .payload_t (link_rsp_s),
    .depth_p   (`LINK_FIFO_DEPTH)
  ) u_rsp_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .data_i  (ep_rsp),
    .v_i     (ep_rsp_v),
    .ready_o (ep_rsp_ready),
    .data_o  (pk_rsp),
    .v_o     (pk_rsp_v),
    .ready_i (pk_rsp_ready)
  );

endmodule

// ==== verif/axil_link_assertions.sv ====
// ================================================
// AXI4-Lite store packer assertions
// Protocol rules on the AXI responses and the
// link command output
// ================================================

`timescale 1ns/10ps

module axil_link_assertions
  import axil_link_pkg::*;
(
  input logic      clk_i,
  input logic      reset_i,
  input logic      bvalid_i,
  input logic      rvalid_i,
  input link_cmd_s cmd_i,
  input logic      cmd_v_i,
  input logic      cmd_ready_i
);

  // Only one transaction is ever in flight
  resp_exclusive_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(bvalid_i && rvalid_i))
    else $error("BVALID and RVALID are high in the same cycle");

  // Command held until the FIFO takes it
  cmd_stable_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_i && !cmd_ready_i) |=> (cmd_v_i && $stable(cmd_i)))
    else $error("link command dropped or changed before it was taken");

  reset_quiet_a: assert property (@(posedge clk_i)
    reset_i |=> (!bvalid_i && !rvalid_i))
    else $error("response valid high in the cycle after reset");

endmodule

bind axil_store_packer axil_link_assertions u_packer_assertions (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .bvalid_i    (s_axil_bvalid_o),
  .rvalid_i    (s_axil_rvalid_o),
  .cmd_i       (cmd_o),
  .cmd_v_i     (cmd_v_o),
  .cmd_ready_i (cmd_ready_i)
);

// ==== verif/axil_link_tb.sv ====
// ================================================
// AXI4-Lite link testbench
// Directed tests checked against a byte model of
// the remote store
// ================================================

`timescale 1ns/10ps

`include "axil_link_macros.svh"

module axil_link_tb
  import axil_link_pkg::*;
();

  localparam int timeout_lp  = 1000;
  localparam int rand_ops_lp = 200;

  logic                      clk_i;
  logic                      reset_i;
  logic [`AXIL_ADDR_W-1:0]   awaddr;
  logic [2:0]                awprot;
  logic                      awvalid;
  logic                      awready;
  logic [`AXIL_DATA_W-1:0]   wdata;
  logic [`AXIL_DATA_W/8-1:0] wstrb;
  logic                      wvalid;
  logic                      wready;
  axil_resp_e                bresp;
  logic                      bvalid;
  logic                      bready;
  logic [`AXIL_ADDR_W-1:0]   araddr;
  logic [2:0]                arprot;
  logic                      arvalid;
  logic                      arready;
  logic [`AXIL_DATA_W-1:0]   rdata;
  axil_resp_e                rresp;
  logic                      rvalid;
  logic                      rready;

  integer seed = 97;
  int     mismatch_count = 0;
  int     other_count = 0;
  logic   aborted = 1'b0;
  time    b_done_time;
  time    ar_done_time;

  // Expected contents of the remote byte store
  logic [`LINK_DATA_W-1:0] model_mem [1 << `MEM_ADDR_W];

  axil_link_top UUT (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .s_axil_awaddr_i  (awaddr),
    .s_axil_awprot_i  (awprot),
    .s_axil_awvalid_i (awvalid),
    .s_axil_awready_o (awready),
    .s_axil_wdata_i   (wdata),
    .s_axil_wstrb_i   (wstrb),
    .s_axil_wvalid_i  (wvalid),
    .s_axil_wready_o  (wready),
    .s_axil_bresp_o   (bresp),
    .s_axil_bvalid_o  (bvalid),
    .s_axil_bready_i  (bready),
    .s_axil_araddr_i  (araddr),
    .s_axil_arprot_i  (arprot),
    .s_axil_arvalid_i (arvalid),
    .s_axil_arready_o (arready),
    .s_axil_rdata_o   (rdata),
    .s_axil_rresp_o   (rresp),
    .s_axil_rvalid_o  (rvalid),
    .s_axil_rready_i  (rready)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic link_rsp_s model_rsp(input logic [`AXIL_ADDR_W-1:0] addr);
    link_rsp_s rsp;
    rsp.pad  = '0;
    rsp.data = model_mem[addr[`MEM_ADDR_W-1:0]];
    return rsp;
  endfunction

  task automatic check_resp(input string test, input axil_resp_e exp, input axil_resp_e act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH %s: resp expected %s, actual %s", test, exp.name(), act.name());
    end
  endtask

  task automatic check_rdata(input string test, input link_rsp_s exp, input link_rsp_s act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH %s: rdata expected 0x%08h, actual 0x%08h", test, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input string sig, input logic exp,
                            input logic act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("MISMATCH %s: %s expected %0b, actual %0b", test, sig, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    other_count++;
    aborted = 1'b1;
    $display("ERROR: no %s within %0d cycles, run aborted", what, timeout_lp);
  endtask

  // Reset pulse in mid run with the model cleared to match the sweep
  task automatic pulse_reset();
    int a;
    @(negedge clk_i);
    reset_i = 1'b1;
    for (a = 0; a < (1 << `MEM_ADDR_W); a++)
      model_mem[a] = '0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
  endtask

  // One write with B held off for hold cycles while a read is offered
  task automatic axil_write(input string test, input logic [`AXIL_ADDR_W-1:0] addr,
                            input logic [`AXIL_DATA_W-1:0] data,
                            input logic [`AXIL_DATA_W/8-1:0] strb,
                            input logic [2:0] prot, input int hold);
    int waited;
    int i;
    @(negedge clk_i);
    awaddr  = addr;
    awprot  = prot;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    while (!(awready && wready) && waited < timeout_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    @(negedge clk_i);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (waited >= timeout_lp)
    begin
      note_timeout("AWREADY and WREADY");
      return;
    end
    waited = 0;
    while (!bvalid && waited < timeout_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (!bvalid)
    begin
      note_timeout("BVALID");
      return;
    end
    check_resp(test, OKAY, bresp);
    if (hold > 0)
    begin
      araddr  = addr;
      arvalid = 1'b1;
    end
    for (i = 0; i < hold; i++)
    begin
      @(negedge clk_i);
      check_flag(test, "bvalid", 1'b1, bvalid);
      check_resp(test, OKAY, bresp);
      check_flag(test, "arready", 1'b0, arready);
    end
    if (hold > 0)
      arvalid = 1'b0;
    bready      = 1'b1;
    b_done_time = $time;
    model_mem[addr[`MEM_ADDR_W-1:0]] = data[`LINK_DATA_W-1:0];
    @(negedge clk_i);
    bready = 1'b0;
  endtask

  // One read with R held off for hold cycles while a write is offered
  task automatic axil_read(input string test, input logic [`AXIL_ADDR_W-1:0] addr,
                           input int hold, output link_rsp_s data, output axil_resp_e resp);
    int waited;
    int i;
    data = '0;
    resp = OKAY;
    @(negedge clk_i);
    araddr  = addr;
    arprot  = 3'($random(seed));
    arvalid = 1'b1;
    waited  = 0;
    while (!arready && waited < timeout_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    ar_done_time = $time;
    @(negedge clk_i);
    arvalid = 1'b0;
    if (waited >= timeout_lp)
    begin
      note_timeout("ARREADY");
      return;
    end
    waited = 0;
    while (!rvalid && waited < timeout_lp)
    begin
      @(negedge clk_i);
      waited++;
    end
    if (!rvalid)
    begin
      note_timeout("RVALID");
      return;
    end
    data = link_rsp_s'(rdata);
    resp = rresp;
    if (hold > 0)
    begin
      awaddr  = addr;
      wdata   = '1;
      awvalid = 1'b1;
      wvalid  = 1'b1;
    end
    for (i = 0; i < hold; i++)
    begin
      @(negedge clk_i);
      check_flag(test, "rvalid", 1'b1, rvalid);
      check_rdata(test, model_rsp(addr), link_rsp_s'(rdata));
      check_flag(test, "awready", 1'b0, awready);
      check_flag(test, "wready", 1'b0, wready);
    end
    awvalid = 1'b0;
    wvalid  = 1'b0;
    rready  = 1'b1;
    @(negedge clk_i);
    rready = 1'b0;
  endtask

  task automatic read_check(input string test, input logic [`AXIL_ADDR_W-1:0] addr,
                            input int hold);
    link_rsp_s  data;
    axil_resp_e resp;
    axil_read(test, addr, hold, data, resp);
    if (!aborted)
    begin
      check_resp(test, OKAY, resp);
      check_rdata(test, model_rsp(addr), data);
    end
  endtask

  task automatic reset_defaults();
    logic [`AXIL_ADDR_W-1:0] addrs [5];
    int                      i;
    addrs = '{32'h0000_0000, 32'h0000_00ff, 32'h0012_3456, 32'h0000_0011, 32'h0000_0022};
    // Five writes during the clear sweep overfill the command FIFO
    for (i = 0; i < 5 && !aborted; i++)
      axil_write("reset_defaults", addrs[i], 32'h0000_00a0 + i, 4'hf, 3'b000, 0);
    read_check("reset_defaults", addrs[4], 0);
    pulse_reset();
    check_flag("reset_defaults", "bvalid", 1'b0, bvalid);
    check_flag("reset_defaults", "rvalid", 1'b0, rvalid);
    for (i = 0; i < 5 && !aborted; i++)
      read_check("reset_defaults", addrs[i], 0);
  endtask

  task automatic write_read_back();
    axil_write("write_read", 32'h0000_0005, 32'h0000_005a, 4'hf, 3'b000, 0);
    axil_write("write_read", 32'h0000_0080, 32'h0000_0081, 4'hf, 3'b000, 0);
    read_check("write_read", 32'h0000_0005, 0);
    read_check("write_read", 32'h0000_0080, 0);
  endtask

  task automatic truncate_alias();
    axil_write("truncate", 32'h0000_0010, 32'hdead_bea5, 4'hf, 3'b000, 0);
    read_check("truncate", 32'h0000_0010, 0);
    // Upper bits dropped by the packer and by the endpoint decode
    axil_write("alias", 32'h0000_0120, 32'h0000_003c, 4'hf, 3'b000, 0);
    read_check("alias", 32'h0000_0020, 0);
    read_check("alias", 32'h0007_ff20, 0);
    read_check("alias", 32'h8000_0020, 0);
    axil_write("strb_prot", 32'h0000_0030, 32'h0000_0077, 4'h0, 3'b111, 0);
    read_check("strb_prot", 32'h0000_0030, 0);
  endtask

  task automatic backpressure_hold();
    int i;
    for (i = 0; i < 4 && !aborted; i++)
    begin
      axil_write("backpressure", 32'h40 + i, 32'($random(seed)), 4'hf, 3'b000,
                 1 + ($random(seed) & 15));
      read_check("backpressure", 32'h40 + i, 1 + ($random(seed) & 15));
    end
  endtask

  task automatic simultaneous_requests();
    link_rsp_s  data;
    axil_resp_e resp;
    axil_write("simultaneous", 32'h0000_0066, 32'h0000_0011, 4'hf, 3'b000, 0);
    fork
      axil_write("simultaneous", 32'h0000_0066, 32'h0000_00c3, 4'hf, 3'b000, 0);
      axil_read("simultaneous", 32'h0000_0066, 0, data, resp);
    join
    if (!aborted)
    begin
      if (ar_done_time <= b_done_time)
      begin
        other_count++;
        $display("ERROR: simultaneous read was accepted before the write completed");
      end
      check_resp("simultaneous", OKAY, resp);
      check_rdata("simultaneous", model_rsp(32'h0000_0066), data);
    end
  endtask

  task automatic random_traffic();
    logic [`AXIL_ADDR_W-1:0] addr;
    int                      n;
    for (n = 0; n < rand_ops_lp && !aborted; n++)
    begin
      // Few distinct bytes and random upper bits so aliases collide
      addr = $random(seed);
      addr = addr & 32'hffff_ff1f;
      if ($random(seed) & 1)
        axil_write("random", addr, $random(seed), 4'($random(seed)), 3'($random(seed)),
                   $random(seed) & 3);
      else
        read_check("random", addr, $random(seed) & 3);
    end
  endtask

  initial
  begin
    reset_i = 1'b1;
    awaddr  = '0;
    awprot  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arprot  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    // Remote memory is cleared by its reset sweep
    for (int a = 0; a < (1 << `MEM_ADDR_W); a++)
      model_mem[a] = '0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;

    reset_defaults();
    if (!aborted)
      write_read_back();
    if (!aborted)
      truncate_alias();
    if (!aborted)
      backpressure_hold();
    if (!aborted)
      simultaneous_requests();
    if (!aborted)
      random_traffic();

    $display("Summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== axil_link.f ====
+incdir+hdl
hdl/axil_link_pkg.sv
hdl/link_fifo.sv
hdl/axil_store_packer.sv
hdl/store_endpoint.sv
hdl/axil_link_top.sv
verif/axil_link_assertions.sv
verif/axil_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXI4-Lite link project

VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = axil_link_tb
FILELIST  = axil_link.f
MDIR      = obj_dir
PASS_MSG  = NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)
